//--- Bender.yml
package:
  name: video_daisy

sources:
  - src/video_pkg.sv
  - src/video_csr_pkg.sv
  - src/video_stream_if.sv
  - src/vga_frame_counter.sv
  - src/video_bar_core.sv
  - src/video_sprite_core.sv
  - src/video_rgb2gray_core.sv
  - src/video_daisy_core.sv
  - target: simulation
    files:
      - testbench/tb_video_daisy_core.sv

//--- src/vga_frame_counter.sv
// ------------------------------
// Frame position generator
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module vga_frame_counter import video_pkg::*; #(
    parameter int H_ACTIVE = 32,                  // Frame width
    parameter int V_ACTIVE = 24                   // Frame height
) (
    input  logic        sys_clk,
    input  logic        rst_n,
    video_stream_if.src src
);

    hcount_t hc;                                  // Current column
    vcount_t vc;                                  // Current row
    logic    vld_q;                               // Up after reset
    logic    adv;                                 // Item accepted
    logic    line_end;                            // Last column

    assign adv      = src.vld && src.rdy;
    assign line_end = (hc == hcount_t'(H_ACTIVE - 1));

    // No blanking, so the source is always valid
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
            hc    <= '0;
            vc    <= '0;
        end else begin
            vld_q <= 1'b1;
            if (adv) begin
                if (line_end) begin
                    hc <= '0;                     // Next line
                    if (vc == vcount_t'(V_ACTIVE - 1)) begin
                        vc <= '0;                 // Frame wrap
                    end else begin
                        vc <= vc + 1'b1;
                    end
                end else begin
                    hc <= hc + 1'b1;
                end
            end
        end
    end

    assign src.vld            = vld_q;
    assign src.rgb            = '0;               // Black canvas
    assign src.fc.hc          = hc;
    assign src.fc.vc          = vc;
    assign src.fc.frame_start = (hc == '0) && (vc == '0);

    // Column never leaves the active width
    a_hc_range: assert property (@(posedge sys_clk) disable iff (!rst_n)
        int'(hc) < H_ACTIVE);

endmodule

`default_nettype wire

//--- src/video_bar_core.sv
// ------------------------------
// Colour bar stage
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module video_bar_core import video_pkg::*, video_csr_pkg::*; #(
    parameter int H_ACTIVE = 32                   // Frame width for bar split
) (
    input  logic                  sys_clk,
    input  logic                  rst_n,
    input  logic [BAR_AVS_AW-1:0] avs_address,
    input  logic                  avs_write,
    input  avs_data_t             avs_writedata,
    video_stream_if.snk           snk,
    video_stream_if.src           src
);

    localparam int IDX_W = $clog2(BAR_NUM);

    logic             bar_en;                     // Bars vs background
    rgb_t             bg_color;                   // Flat colour
    logic [IDX_W-1:0] bar_idx;                    // Bar under this column
    logic             load;                       // Output stage free
    logic             vld_q;
    vga_fc_t          fc_q;
    rgb_t             rgb_q;

    // ------------------------------
    // Registers
    // ------------------------------
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            bar_en   <= 1'b0;
            bg_color <= '0;
        end else if (avs_write) begin
            case (avs_address)
                BAR_REG_CTRL: bar_en   <= avs_writedata[BAR_CTRL_EN];
                BAR_REG_BG:   bg_color <= avs_writedata[$bits(rgb_t)-1:0];
                default: ;
            endcase
        end
    end

    // ------------------------------
    // Pipeline stage
    // ------------------------------
    assign bar_idx = IDX_W'((int'(snk.fc.hc) * BAR_NUM) / H_ACTIVE);
    assign load    = !vld_q || src.rdy;
    assign snk.rdy = load;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else if (load) begin
            vld_q <= snk.vld;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (load) begin
            fc_q  <= snk.fc;                      // Coordinate rides along
            rgb_q <= bar_en ? BAR_COLORS[bar_idx] : bg_color;
        end
    end

    assign src.vld = vld_q;
    assign src.fc  = fc_q;
    assign src.rgb = rgb_q;

    // Held item must not move while stalled
    a_stall_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        src.vld && !src.rdy |=> src.vld && $stable(src.fc) && $stable(src.rgb));

endmodule

`default_nettype wire

//--- src/video_csr_pkg.sv
// ------------------------------
// Video core register map
// ------------------------------
`default_nettype none

package video_csr_pkg;

    typedef logic [31:0] avs_data_t;              // Avalon write data

    // ------------------------------
    // Bar core
    // ------------------------------
    localparam int BAR_AVS_AW = 1;                // Two registers
    localparam logic [BAR_AVS_AW-1:0] BAR_REG_CTRL = 1'b0;
    localparam logic [BAR_AVS_AW-1:0] BAR_REG_BG   = 1'b1;
    localparam int BAR_CTRL_EN = 0;               // 1 = bars, 0 = background

    // ------------------------------
    // Sprite core
    // ------------------------------
    localparam int SPRITE_AVS_AW    = 7;          // RAM plus registers
    localparam int SPRITE_RAM_DEPTH = 64;         // 8x8 pixels in row-major order
    localparam logic [SPRITE_AVS_AW-1:0] SPRITE_REG_X    = 7'd64;
    localparam logic [SPRITE_AVS_AW-1:0] SPRITE_REG_Y    = 7'd65;
    localparam logic [SPRITE_AVS_AW-1:0] SPRITE_REG_CTRL = 7'd66;
    localparam int SPRITE_CTRL_EN = 0;            // Overlay enable

    localparam int GRAY_CTRL_EN = 0;              // Grey conversion enable

endpackage

`default_nettype wire

//--- src/video_daisy_core.sv
// ------------------------------
// Video daisy chain top
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

// Frame counter -> bar core -> sprite core -> grey core -> ports
module video_daisy_core import video_pkg::*, video_csr_pkg::*; #(
    parameter int H_ACTIVE = 32,                  // Frame width
    parameter int V_ACTIVE = 24                   // Frame height
) (
    input  logic                     sys_clk,
    input  logic                     rst_n,

    // Stream output
    output vga_fc_t                  daisy_system_fc,
    output rgb_t                     daisy_system_rgb,
    output logic                     daisy_system_vld,
    input  logic                     daisy_system_rdy,

    // Avalon slaves
    input  logic [BAR_AVS_AW-1:0]    avs_video_bar_core_address,
    input  logic                     avs_video_bar_core_write,
    input  avs_data_t                avs_video_bar_core_writedata,
    input  logic [SPRITE_AVS_AW-1:0] avs_video_sprite_core_address,
    input  logic                     avs_video_sprite_core_write,
    input  avs_data_t                avs_video_sprite_core_writedata,
    input  logic                     avs_video_rgb2gray_core_write,
    input  avs_data_t                avs_video_rgb2gray_core_writedata
);

    // ------------------------------
    // Links between stages
    // ------------------------------
    video_stream_if fc_to_bar ();
    video_stream_if bar_to_sprite ();
    video_stream_if sprite_to_gray ();
    video_stream_if gray_out ();                  // Unpacked to plain ports

    assign daisy_system_fc  = gray_out.fc;
    assign daisy_system_rgb = gray_out.rgb;
    assign daisy_system_vld = gray_out.vld;
    assign gray_out.rdy     = daisy_system_rdy;

    // ------------------------------
    // Stages
    // ------------------------------
    vga_frame_counter #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) u_vga_frame_counter (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .src     (fc_to_bar.src)
    );

    video_bar_core #(
        .H_ACTIVE (H_ACTIVE)
    ) u_bar_core (
        .sys_clk       (sys_clk),
        .rst_n         (rst_n),
        .avs_address   (avs_video_bar_core_address),
        .avs_write     (avs_video_bar_core_write),
        .avs_writedata (avs_video_bar_core_writedata),
        .snk           (fc_to_bar.snk),
        .src           (bar_to_sprite.src)
    );

    video_sprite_core u_sprite_core (
        .sys_clk       (sys_clk),
        .rst_n         (rst_n),
        .avs_address   (avs_video_sprite_core_address),
        .avs_write     (avs_video_sprite_core_write),
        .avs_writedata (avs_video_sprite_core_writedata),
        .snk           (bar_to_sprite.snk),
        .src           (sprite_to_gray.src)
    );

    video_rgb2gray_core u_video_rgb2gray_core (
        .sys_clk       (sys_clk),
        .rst_n         (rst_n),
        .avs_write     (avs_video_rgb2gray_core_write),
        .avs_writedata (avs_video_rgb2gray_core_writedata),
        .snk           (sprite_to_gray.snk),
        .src           (gray_out.src)
    );

endmodule

`default_nettype wire

//--- src/video_pkg.sv
// ------------------------------
// Video pixel and frame types
// ------------------------------
`default_nettype none

package video_pkg;

    // ------------------------------
    // Fixed 4:4:4 pixel format
    // ------------------------------
    typedef logic [3:0]  chan_t;                  // One colour channel
    typedef logic [11:0] rgb_t;                   // R[11:8] G[7:4] B[3:0]

    typedef logic [9:0]  hcount_t;                // Horizontal position
    typedef logic [9:0]  vcount_t;                // Vertical position

    // Frame coordinate carried with every pixel
    typedef struct packed {
        hcount_t hc;                              // Column
        vcount_t vc;                              // Row
        logic    frame_start;                     // High at (0,0) only
    } vga_fc_t;

    // ------------------------------
    // Colour bars
    // ------------------------------
    localparam int   BAR_NUM = 8;                 // Bars across the frame
    localparam rgb_t BAR_COLORS [BAR_NUM] = '{    // Index bits are R, G, B
        12'h000, 12'h00f, 12'h0f0, 12'h0ff,
        12'hf00, 12'hf0f, 12'hff0, 12'hfff
    };

    localparam int   SPRITE_SIZE = 8;             // Sprite edge in pixels
    localparam rgb_t SPRITE_KEY  = 12'hf0f;       // Transparent colour

endpackage

`default_nettype wire

//--- src/video_rgb2gray_core.sv
// ------------------------------
// Grey-scale stage
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module video_rgb2gray_core import video_pkg::*, video_csr_pkg::*; (
    input  logic        sys_clk,
    input  logic        rst_n,
    input  logic        avs_write,
    input  avs_data_t   avs_writedata,
    video_stream_if.snk snk,
    video_stream_if.src src
);

    logic       gray_en;                          // Conversion on
    chan_t      r;
    chan_t      g;
    chan_t      b;
    logic [5:0] luma_sum;                         // R + 2G + B peaks at 60
    chan_t      gray;
    logic       load;
    logic       vld_q;
    vga_fc_t    fc_q;
    rgb_t       rgb_q;

    // Single control register
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            gray_en <= 1'b0;
        end else if (avs_write) begin
            gray_en <= avs_writedata[GRAY_CTRL_EN];
        end
    end

    assign {r, g, b} = snk.rgb;
    assign luma_sum  = 6'(r) + {1'b0, g, 1'b0} + 6'(b);
    assign gray      = luma_sum[5:2];             // Truncating divide by 4

    // ------------------------------
    // Pipeline stage
    // ------------------------------
    assign load    = !vld_q || src.rdy;
    assign snk.rdy = load;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else if (load) begin
            vld_q <= snk.vld;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (load) begin
            fc_q  <= snk.fc;
            rgb_q <= gray_en ? {gray, gray, gray} : snk.rgb;
        end
    end

    assign src.vld = vld_q;
    assign src.fc  = fc_q;
    assign src.rgb = rgb_q;

    // Output side stays quiet through reset
    a_rst_quiet: assert property (@(posedge sys_clk) !rst_n |-> !src.vld);

endmodule

`default_nettype wire

//--- src/video_sprite_core.sv
// ------------------------------
// Sprite overlay stage
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module video_sprite_core import video_pkg::*, video_csr_pkg::*; (
    input  logic                     sys_clk,
    input  logic                     rst_n,
    input  logic [SPRITE_AVS_AW-1:0] avs_address,
    input  logic                     avs_write,
    input  avs_data_t                avs_writedata,
    video_stream_if.snk              snk,
    video_stream_if.src              src
);

    localparam int SPR_AW = $clog2(SPRITE_RAM_DEPTH);   // RAM index width
    localparam int SPR_OW = $clog2(SPRITE_SIZE);        // Offset width

    rgb_t              sprite_ram [SPRITE_RAM_DEPTH];   // Sprite image
    hcount_t           spr_x;                     // Origin column
    vcount_t           spr_y;                     // Origin row
    logic              spr_en;                    // Overlay on
    logic              ram_sel;                   // Write targets RAM
    hcount_t           dx;                        // Offset into sprite
    vcount_t           dy;
    logic              in_win;                    // Inside 8x8 window
    logic [SPR_AW-1:0] spr_idx;
    rgb_t              spr_pix;
    logic              hit;                       // Sprite pixel wins
    logic              load;
    logic              vld_q;
    vga_fc_t           fc_q;
    rgb_t              rgb_q;

    // ------------------------------
    // Avalon writes
    // ------------------------------
    assign ram_sel = (int'(avs_address) < SPRITE_RAM_DEPTH);

    always_ff @(posedge sys_clk) begin
        if (avs_write && ram_sel) begin
            sprite_ram[avs_address[SPR_AW-1:0]] <= avs_writedata[$bits(rgb_t)-1:0];
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            spr_x  <= '0;
            spr_y  <= '0;
            spr_en <= 1'b0;
        end else if (avs_write && !ram_sel) begin
            case (avs_address)
                SPRITE_REG_X:    spr_x  <= avs_writedata[$bits(hcount_t)-1:0];
                SPRITE_REG_Y:    spr_y  <= avs_writedata[$bits(vcount_t)-1:0];
                SPRITE_REG_CTRL: spr_en <= avs_writedata[SPRITE_CTRL_EN];
                default: ;
            endcase
        end
    end

    // ------------------------------
    // Window and lookup
    // ------------------------------
    assign dx = snk.fc.hc - spr_x;                // Only meaningful inside
    assign dy = snk.fc.vc - spr_y;

    assign in_win = (snk.fc.hc >= spr_x) && (int'(dx) < SPRITE_SIZE) &&
                    (snk.fc.vc >= spr_y) && (int'(dy) < SPRITE_SIZE);

    assign spr_idx = {dy[SPR_OW-1:0], dx[SPR_OW-1:0]};  // Row-major
    assign spr_pix = sprite_ram[spr_idx];
    assign hit     = spr_en && in_win && (spr_pix != SPRITE_KEY);

    // ------------------------------
    // Pipeline stage
    // ------------------------------
    assign load    = !vld_q || src.rdy;
    assign snk.rdy = load;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else if (load) begin
            vld_q <= snk.vld;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (load) begin
            fc_q  <= snk.fc;
            rgb_q <= hit ? spr_pix : snk.rgb;     // Key shows the layer below
        end
    end

    assign src.vld = vld_q;
    assign src.fc  = fc_q;
    assign src.rgb = rgb_q;

    a_stall_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        src.vld && !src.rdy |=> src.vld && $stable(src.fc) && $stable(src.rgb));

endmodule

`default_nettype wire

//--- src/video_stream_if.sv
// ------------------------------
// Video stream link
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

interface video_stream_if import video_pkg::*;;

    vga_fc_t fc;                                  // Frame coordinate
    rgb_t    rgb;                                 // Pixel colour
    logic    vld;                                 // Item present
    logic    rdy;                                 // Sink can take it

    // Producer side
    modport src (
        output fc,
        output rgb,
        output vld,
        input  rdy
    );

    // Consumer side
    modport snk (
        input  fc,
        input  rgb,
        input  vld,
        output rdy
    );

endinterface

`default_nettype wire

//--- testbench/tb_video_daisy_core.sv
// ------------------------------
// Video daisy chain testbench
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_video_daisy_core import video_pkg::*, video_csr_pkg::*;;

    localparam int H_ACTIVE  = 32;
    localparam int V_ACTIVE  = 24;
    localparam int FRAME_PIX = H_ACTIVE * V_ACTIVE;

    logic                     sys_clk;
    logic                     rst_n;
    vga_fc_t                  daisy_system_fc;
    rgb_t                     daisy_system_rgb;
    logic                     daisy_system_vld;
    logic                     daisy_system_rdy;
    logic [BAR_AVS_AW-1:0]    bar_address;
    logic                     bar_wr;
    avs_data_t                bar_writedata;
    logic [SPRITE_AVS_AW-1:0] sprite_address;
    logic                     sprite_wr;
    avs_data_t                sprite_writedata;
    logic                     gray_wr;
    avs_data_t                gray_writedata;

    // Shadow of the register state kept by the write tasks
    logic bar_on;
    rgb_t bg_color;
    logic spr_on;
    int   spr_x;
    int   spr_y;
    rgb_t sprite_img [SPRITE_SIZE*SPRITE_SIZE];
    logic gray_on;

    // ------------------------------
    // Scoreboard state
    // ------------------------------
    string   test_name;
    logic    accepted;                            // Output transfer this cycle
    logic    hold_rdy;                            // Forces back-pressure
    logic    timed_out;
    int      acc_count;                           // Accepted output items
    int      check_from;                          // First item with new config
    int      checked;
    int      value_errors;
    int      protocol_errors;
    hcount_t exp_hc;                              // Next raster position
    vcount_t exp_vc;
    vga_fc_t exp_fc;
    rgb_t    exp_rgb;

    video_daisy_core #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) video_daisy_core_inst (
        .sys_clk                           (sys_clk),
        .rst_n                             (rst_n),
        .daisy_system_fc                   (daisy_system_fc),
        .daisy_system_rgb                  (daisy_system_rgb),
        .daisy_system_vld                  (daisy_system_vld),
        .daisy_system_rdy                  (daisy_system_rdy),
        .avs_video_bar_core_address        (bar_address),
        .avs_video_bar_core_write          (bar_wr),
        .avs_video_bar_core_writedata      (bar_writedata),
        .avs_video_sprite_core_address     (sprite_address),
        .avs_video_sprite_core_write       (sprite_wr),
        .avs_video_sprite_core_writedata   (sprite_writedata),
        .avs_video_rgb2gray_core_write     (gray_wr),
        .avs_video_rgb2gray_core_writedata (gray_writedata)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;            // 8 ns period
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32,22,2,1
    endfunction

    function automatic rgb_t bar_rgb(input int idx);
        return {idx[2] ? 4'hf : 4'h0, idx[1] ? 4'hf : 4'h0, idx[0] ? 4'hf : 4'h0};
    endfunction

    function automatic rgb_t sprite_pattern(input int i);
        if (i % 5 == 0) begin
            return SPRITE_KEY;                    // Holes in the sprite
        end
        return {i[5:0], ~i[5:0]};                 // Never equals the key
    endfunction

    function automatic rgb_t model_rgb(input vga_fc_t fc);
        int   hc;
        int   vc;
        int   sum;
        rgb_t c;
        rgb_t p;
        hc = int'(fc.hc);
        vc = int'(fc.vc);
        c  = bar_on ? bar_rgb(hc * 8 / H_ACTIVE) : bg_color;
        if (spr_on && hc >= spr_x && hc < spr_x + SPRITE_SIZE &&
            vc >= spr_y && vc < spr_y + SPRITE_SIZE) begin
            p = sprite_img[(vc - spr_y) * SPRITE_SIZE + hc - spr_x];
            if (p != SPRITE_KEY) begin
                c = p;
            end
        end
        if (gray_on) begin
            sum = c[11:8] + 2 * c[7:4] + c[3:0];
            c   = {3{4'(sum / 4)}};
        end
        return c;
    endfunction

    assign accepted = daisy_system_vld && daisy_system_rdy;
    assign exp_fc   = '{hc: exp_hc, vc: exp_vc, frame_start: (exp_hc == '0 && exp_vc == '0)};

    always_comb exp_rgb = model_rgb(exp_fc);

    always @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_hc    <= '0;
            exp_vc    <= '0;
            acc_count <= 0;
        end else if (accepted) begin
            acc_count <= acc_count + 1;
            if (acc_count >= check_from) checked <= checked + 1;
            if (int'(exp_hc) == H_ACTIVE - 1) begin
                exp_hc <= '0;
                exp_vc <= (int'(exp_vc) == V_ACTIVE - 1) ? '0 : exp_vc + 1'b1;
            end else begin
                exp_hc <= exp_hc + 1'b1;
            end
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    a_reset_quiet: assert property (@(posedge sys_clk) !rst_n |-> !daisy_system_vld)
        else begin
            protocol_errors++;
            $display("daisy_system_vld was high during reset");
        end

    a_raster: assert property (@(posedge sys_clk) disable iff (!rst_n)
        accepted |-> daisy_system_fc == exp_fc)
        else begin
            value_errors++;
            $display("FAIL %s: fc expected %h actual %h", test_name,
                     $sampled(exp_fc), $sampled(daisy_system_fc));
        end

    a_pixel: assert property (@(posedge sys_clk) disable iff (!rst_n)
        accepted && acc_count >= check_from |-> daisy_system_rgb == exp_rgb)
        else begin
            value_errors++;
            $display("FAIL %s: rgb at (%0d,%0d) expected %h actual %h", test_name,
                     $sampled(daisy_system_fc.hc), $sampled(daisy_system_fc.vc),
                     $sampled(exp_rgb), $sampled(daisy_system_rgb));
        end

    a_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        daisy_system_vld && !daisy_system_rdy |=>
        daisy_system_vld && $stable(daisy_system_fc) && $stable(daisy_system_rgb))
        else begin
            protocol_errors++;
            $display("output item changed while the sink was not ready");
        end

    // Random ready about 3 of 4 cycles
    initial begin
        logic [31:0] lfsr;
        logic        bit_a;
        logic        bit_b;
        lfsr             = 32'h8a6a_1d21;
        daisy_system_rdy = 1'b0;
        forever begin
            @(posedge sys_clk);
            #1;
            lfsr             = lfsr_step(lfsr);
            bit_a            = lfsr[0];
            lfsr             = lfsr_step(lfsr);
            bit_b            = lfsr[0];
            daisy_system_rdy = !hold_rdy && (bit_a || bit_b);
        end
    end

    // ------------------------------
    // Tasks
    // ------------------------------
    task automatic wait_items(input int n);
        int target;
        int cycles;
        target = acc_count + n;
        cycles = 0;
        while (!timed_out && acc_count < target) begin
            @(posedge sys_clk);
            cycles++;
            if (cycles > 4 * n + 64) begin
                timed_out = 1'b1;
                $display("output stream stalled during %s", test_name);
            end
        end
    endtask

    // Stall the sink so the three stages fill, then freeze the count
    task automatic pause_stream();
        hold_rdy = 1'b1;
        repeat (5) @(posedge sys_clk);
        check_from = acc_count + 3;               // Stage contents are stale
    endtask

    task automatic resume_stream(input string name);
        test_name = name;
        hold_rdy  = 1'b0;
    endtask

    task automatic bar_write(input logic [BAR_AVS_AW-1:0] addr, input avs_data_t data);
        @(posedge sys_clk);
        #1;
        bar_address   = addr;
        bar_writedata = data;
        bar_wr        = 1'b1;
        @(posedge sys_clk);
        #1;
        bar_wr = 1'b0;
        if (addr == BAR_REG_CTRL) bar_on = data[BAR_CTRL_EN];
        else bg_color = data[11:0];
    endtask

    task automatic sprite_write(input logic [SPRITE_AVS_AW-1:0] addr, input avs_data_t data);
        @(posedge sys_clk);
        #1;
        sprite_address   = addr;
        sprite_writedata = data;
        sprite_wr        = 1'b1;
        @(posedge sys_clk);
        #1;
        sprite_wr = 1'b0;
        if (int'(addr) < SPRITE_RAM_DEPTH) sprite_img[addr] = data[11:0];
        else if (addr == SPRITE_REG_X) spr_x = int'(data[9:0]);
        else if (addr == SPRITE_REG_Y) spr_y = int'(data[9:0]);
        else if (addr == SPRITE_REG_CTRL) spr_on = data[SPRITE_CTRL_EN];
    endtask

    task automatic gray_write(input avs_data_t data);
        @(posedge sys_clk);
        #1;
        gray_writedata = data;
        gray_wr        = 1'b1;
        @(posedge sys_clk);
        #1;
        gray_wr = 1'b0;
        gray_on = data[GRAY_CTRL_EN];
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        rst_n = 1'b1;
        {bar_address, bar_wr, bar_writedata} = '0;
        {sprite_address, sprite_wr, sprite_writedata} = '0;
        {gray_wr, gray_writedata} = '0;
        {bar_on, bg_color, spr_on, gray_on} = '0;
        spr_x = 0;
        spr_y = 0;
        {hold_rdy, timed_out} = '0;
        {check_from, checked, value_errors, protocol_errors} = '0;
        test_name = "reset_default";
        #1 rst_n = 1'b0;
        repeat (8) @(posedge sys_clk);
        #1 rst_n = 1'b1;

        wait_items(2 * FRAME_PIX);                // Two black frames in raster order

        pause_stream();
        bar_write(BAR_REG_CTRL, 32'd1);
        resume_stream("bars");
        wait_items(FRAME_PIX);

        pause_stream();
        bar_write(BAR_REG_CTRL, 32'd0);
        bar_write(BAR_REG_BG, 32'h5a3);
        resume_stream("background");
        wait_items(FRAME_PIX / 3);

        pause_stream();
        bar_write(BAR_REG_CTRL, 32'd1);           // Bars show through the key
        for (int i = 0; i < SPRITE_RAM_DEPTH; i++) begin
            sprite_write(SPRITE_AVS_AW'(i), avs_data_t'(sprite_pattern(i)));
        end
        sprite_write(SPRITE_REG_X, 32'd20);
        sprite_write(SPRITE_REG_Y, 32'd10);
        sprite_write(SPRITE_REG_CTRL, 32'd1);
        resume_stream("sprite");
        wait_items(FRAME_PIX);

        pause_stream();
        sprite_write(SPRITE_REG_X, 32'd28);       // Right half off the frame
        resume_stream("sprite_clip");
        wait_items(FRAME_PIX);

        pause_stream();
        gray_write(32'd1);
        resume_stream("gray");
        wait_items(FRAME_PIX);

        $display("checked %0d pixels, %0d value errors, %0d protocol errors",
                 checked, value_errors, protocol_errors);
        if (timed_out || value_errors != 0 || protocol_errors != 0) begin
            $display("test failed");
        end else begin
            $display("test passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- video_daisy.f
src/video_pkg.sv
src/video_csr_pkg.sv
src/video_stream_if.sv
src/vga_frame_counter.sv
src/video_bar_core.sv
src/video_sprite_core.sv
src/video_rgb2gray_core.sv
src/video_daisy_core.sv
testbench/tb_video_daisy_core.sv
